//--- core_ctrl.f
+incdir+tests
logic/ctrl_pkg.sv
logic/ctrl_fsm.sv
logic/hazard_unit.sv
logic/operand_fwd_sel.sv
logic/core_ctrl.sv
tests/core_ctrl_tb.sv

//--- logic/core_ctrl.sv
/*
  core controller top, split decode and execute, two read ports.
  no debug interface and no misaligned access support
*/
`timescale 1ns/1ps

module core_ctrl import ctrl_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,

  // core enable and pipeline status
  input  logic    fetch_enable_i,
  input  logic    instr_valid_i,
  input  logic    id_ready_i,
  input  logic    ex_valid_i,
  output logic    instr_req_o,
  output logic    ctrl_busy_o,
  output logic    is_decoding_o,

  // decoder
  input  logic    illegal_insn_i,
  input  logic    eret_insn_i,
  input  logic    pipe_flush_i,
  input  jump_t   jump_in_dec_i,
  output logic    deassert_we_o,

  // execute stage
  input  logic    branch_taken_ex_i,
  input  logic    data_req_ex_i,

  // fetch redirect
  output logic    pc_set_o,
  output pc_mux_t pc_mux_o,

  // exception controller
  input  logic    exc_req_i,
  input  logic    ext_req_i,
  output logic    exc_ack_o,
  output logic    exc_save_if_o,
  output logic    exc_save_id_o,
  output logic    exc_save_takenbranch_o,
  output logic    exc_restore_id_o,

  // register write enables of later stages
  input  logic    regfile_we_ex_i,
  input  logic    regfile_we_wb_i,
  input  logic    regfile_alu_we_fw_i,

  // register match bits from the decoder
  input  logic    reg_d_wb_is_reg_a_i,
  input  logic    reg_d_wb_is_reg_b_i,
  input  logic    reg_d_alu_is_reg_a_i,
  input  logic    reg_d_alu_is_reg_b_i,

  // forwarding selects
  output fw_sel_t operand_a_fw_mux_sel_o,
  output fw_sel_t operand_b_fw_mux_sel_o,

  // stalls
  output logic    halt_if_o,
  output logic    halt_id_o,
  output logic    load_stall_o,
  output logic    jr_stall_o
);

  ////////////////////////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////////////////////////
  ctrl_fsm u_ctrl_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .instr_valid_i          (instr_valid_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .pipe_flush_i           (pipe_flush_i),
    .eret_insn_i            (eret_insn_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .jr_stall_i             (jr_stall_o),
    .instr_req_o            (instr_req_o),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o)
  );

  // jr stall feeds back to the fsm, it does not depend on is_decoding
  hazard_unit u_hazard_unit (
    .is_decoding_i        (is_decoding_o),
    .illegal_insn_i       (illegal_insn_i),
    .jump_in_dec_i        (jump_in_dec_i),
    .data_req_ex_i        (data_req_ex_i),
    .regfile_we_ex_i      (regfile_we_ex_i),
    .regfile_we_wb_i      (regfile_we_wb_i),
    .regfile_alu_we_fw_i  (regfile_alu_we_fw_i),
    .reg_d_wb_is_reg_a_i  (reg_d_wb_is_reg_a_i),
    .reg_d_alu_is_reg_a_i (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i (reg_d_alu_is_reg_b_i),
    .load_stall_o         (load_stall_o),
    .jr_stall_o           (jr_stall_o),
    .deassert_we_o        (deassert_we_o)
  );

  ////////////////////////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////////////////////////
  operand_fwd_sel u_operand_fwd_sel (
    .regfile_we_wb_i        (regfile_we_wb_i),
    .regfile_alu_we_fw_i    (regfile_alu_we_fw_i),
    .reg_d_wb_is_reg_a_i    (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i    (reg_d_wb_is_reg_b_i),
    .reg_d_alu_is_reg_a_i   (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i   (reg_d_alu_is_reg_b_i),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o)
  );

endmodule

//--- logic/ctrl_fsm.sv
/*
  controller FSM, jumps resolved in decode, branches resolved in execute.
  all outputs are combinational from state and inputs; no debug support
*/
`timescale 1ns/1ps

module ctrl_fsm import ctrl_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,

  // start of decoding, and wake condition out of sleep
  input  logic    fetch_enable_i,
  input  logic    instr_valid_i,
  input  logic    id_ready_i,
  input  logic    ex_valid_i,

  // decoder requests
  input  logic    pipe_flush_i,
  input  logic    eret_insn_i,
  input  jump_t   jump_in_dec_i,

  // branch outcome from execute
  input  logic    branch_taken_ex_i,

  // exception controller
  input  logic    exc_req_i,
  input  logic    ext_req_i,

  // from hazard unit
  input  logic    jr_stall_i,

  output logic    instr_req_o,
  output logic    ctrl_busy_o,
  output logic    is_decoding_o,

  // redirect to fetch
  output logic    pc_set_o,
  output pc_mux_t pc_mux_o,

  // pipeline halts
  output logic    halt_if_o,
  output logic    halt_id_o,

  // exception save and restore strobes
  output logic    exc_ack_o,
  output logic    exc_save_if_o,
  output logic    exc_save_id_o,
  output logic    exc_save_takenbranch_o,
  output logic    exc_restore_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set by a redirect, held until decode accepts the next instruction
  logic jump_done_q;
  logic jump_done_d;

  ////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////
  always_comb begin
    // defaults, core running and fetching
    instr_req_o            = 1'b1;
    ctrl_busy_o            = 1'b1;
    is_decoding_o          = 1'b0;
    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;
    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;
    jump_done_d            = jump_done_q;
    state_d                = state_q;

    case (state_q)
      // idle after reset until fetch is enabled
      RESET: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load boot address into fetch
      BOOT_SET: begin
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      // pipeline is empty, wait for enable or an interrupt
      SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach decode
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end

        // interrupt that woke us up, pipe was flushed before sleep
        if (exc_req_i) begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE: begin
        // a taken branch in execute kills the instruction in decode
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (jump_in_dec_i == BRANCH_JAL || jump_in_dec_i == BRANCH_JALR) begin
            // target known in decode
            pc_mux_o = PC_JUMP;
            // wait out a jr stall, and fire only once per jump
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (exc_req_i) begin
            pc_mux_o      = PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_ack_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          if (eret_insn_i) begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi, or eret back to sleep: drain ex and wb first
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // bubble in decode, external interrupt can go right away
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          // keep the bubble out of execute
          halt_id_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end

        // taken branch overrides anything decode wanted
        if (branch_taken_ex_i) begin
          pc_mux_o      = PC_BRANCH;
          pc_set_o      = 1'b1;

          // interrupt on top of the branch, return to the branch target
          if (ext_req_i) begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            halt_id_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
          end
        end
      end

      // insert nop into execute until it completes
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // one cycle for writeback, then resume or sleep
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end else begin
          state_d = SLEEP;
        end
      end

      // unused encodings fall back to reset
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // drops once decode takes the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

//--- logic/ctrl_pkg.sv
/*
  shared encodings for the core controller. pc_mux_t and fw_sel_t values
  must match the fetch stage and the operand muxes in decode
*/
package ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // program counter source, sent to fetch with pc_set
  ////////////////////////////////////////////////////////////
  typedef logic [2:0] pc_mux_t;

  localparam pc_mux_t PC_BOOT      = 3'd0;
  localparam pc_mux_t PC_JUMP      = 3'd1;
  localparam pc_mux_t PC_BRANCH    = 3'd2;
  localparam pc_mux_t PC_EXCEPTION = 3'd3;
  localparam pc_mux_t PC_ERET      = 3'd4;

  ////////////////////////////////////////////////////////////
  // kind of control flow instruction sitting in decode
  ////////////////////////////////////////////////////////////
  typedef logic [1:0] jump_t;

  localparam jump_t BRANCH_NONE = 2'd0;
  localparam jump_t BRANCH_JAL  = 2'd1;
  localparam jump_t BRANCH_JALR = 2'd2;
  localparam jump_t BRANCH_COND = 2'd3;

  ////////////////////////////////////////////////////////////
  // operand forwarding select
  ////////////////////////////////////////////////////////////
  typedef logic [1:0] fw_sel_t;

  localparam fw_sel_t SEL_REGFILE = 2'd0;
  localparam fw_sel_t SEL_FW_EX   = 2'd1;
  localparam fw_sel_t SEL_FW_WB   = 2'd2;

  // controller states
  // flush_ex/flush_wb drain the pipe before sleep or resume
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

endpackage

//--- logic/hazard_unit.sv
/*
  load-use and jump-register hazard detection, purely combinational.
  relies on the decoder's precomputed register match bits
*/
`timescale 1ns/1ps

module hazard_unit import ctrl_pkg::*; (
  input  logic  is_decoding_i,
  input  logic  illegal_insn_i,

  // instruction in decode
  input  jump_t jump_in_dec_i,

  // pending writes further down the pipe
  input  logic  data_req_ex_i,
  input  logic  regfile_we_ex_i,
  input  logic  regfile_we_wb_i,
  input  logic  regfile_alu_we_fw_i,

  // destination matches a decode source
  input  logic  reg_d_wb_is_reg_a_i,
  input  logic  reg_d_alu_is_reg_a_i,
  input  logic  reg_d_alu_is_reg_b_i,

  output logic  load_stall_o,
  output logic  jr_stall_o,
  output logic  deassert_we_o
);

  logic load_hit;
  logic jr_hit;

  // load in execute whose result decode needs on a or b
  assign load_hit = data_req_ex_i && regfile_we_ex_i &&
                    (reg_d_alu_is_reg_a_i || reg_d_alu_is_reg_b_i);

  // jalr target register still in flight, pc cannot be formed yet
  assign jr_hit = (jump_in_dec_i == BRANCH_JALR) &&
                  ((regfile_we_wb_i && reg_d_wb_is_reg_a_i) ||
                   (regfile_we_ex_i && reg_d_alu_is_reg_a_i) ||
                   (regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i));

  // independent of fsm state, only decode and pipe inputs
  assign jr_stall_o = jr_hit;

  ////////////////////////////////////////////////////////////
  // stall and write enable suppression
  ////////////////////////////////////////////////////////////
  always_comb begin
    load_stall_o  = 1'b0;
    deassert_we_o = 1'b0;

    // nothing is being decoded, so nothing may write
    if (!is_decoding_i) begin
      deassert_we_o = 1'b1;
    end

    if (illegal_insn_i) begin
      deassert_we_o = 1'b1;
    end

    if (load_hit) begin
      load_stall_o  = 1'b1;
      deassert_we_o = 1'b1;
    end

    // stalled jalr must not write its link register yet
    if (jr_hit) begin
      deassert_we_o = 1'b1;
    end
  end

endmodule

//--- logic/operand_fwd_sel.sv
/*
  forwarding select for decode operands a and b.
  execute result wins over writeback, being the newer value
*/
`timescale 1ns/1ps

module operand_fwd_sel import ctrl_pkg::*; (
  // write enables of the two forward paths
  input  logic    regfile_we_wb_i,
  input  logic    regfile_alu_we_fw_i,

  // destination matches from the decoder
  input  logic    reg_d_wb_is_reg_a_i,
  input  logic    reg_d_wb_is_reg_b_i,
  input  logic    reg_d_alu_is_reg_a_i,
  input  logic    reg_d_alu_is_reg_b_i,

  output fw_sel_t operand_a_fw_mux_sel_o,
  output fw_sel_t operand_b_fw_mux_sel_o
);

  always_comb begin
    // register file unless a pending write hits
    operand_a_fw_mux_sel_o = SEL_REGFILE;
    operand_b_fw_mux_sel_o = SEL_REGFILE;

    // writeback to decode
    if (regfile_we_wb_i) begin
      if (reg_d_wb_is_reg_a_i) begin
        operand_a_fw_mux_sel_o = SEL_FW_WB;
      end
      if (reg_d_wb_is_reg_b_i) begin
        operand_b_fw_mux_sel_o = SEL_FW_WB;
      end
    end

    // execute to decode, overrides writeback
    if (regfile_alu_we_fw_i) begin
      if (reg_d_alu_is_reg_a_i) begin
        operand_a_fw_mux_sel_o = SEL_FW_EX;
      end
      if (reg_d_alu_is_reg_b_i) begin
        operand_b_fw_mux_sel_o = SEL_FW_EX;
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build the controller testbench with verilator and run it;
# exit status is nonzero unless the pass line appears in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module core_ctrl_tb -f core_ctrl.f -o core_ctrl_sim &&
./obj_dir/core_ctrl_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation did not pass"; exit 1; }

//--- tests/core_ctrl_vectors.svh
/*
  per-cycle table for the controller testbench. each row is applied on one
  rising edge, its expected outputs hold for that cycle
*/
`ifndef CORE_CTRL_VECTORS_SVH
`define CORE_CTRL_VECTORS_SVH

// stim: fe iv ir xv _ illegal eret flush _ jump(2) _ br_taken data_req exc_req ext_req
//       _ we_ex we_wb alu_we_fw _ wb_is_a wb_is_b alu_is_a alu_is_b
// exp:  pc_set _ pc_mux(3) _ halt_if halt_id decoding busy _ exc_ack load_stall jr_stall
//       deassert_we _ instr_req save_if save_id save_takenbranch restore_id
//       _ fw_a(2) _ fw_b(2)
task automatic build_table();
  // reset wait and boot
  add_row("reset_idle",        20'b0000_000_00_0000_000_0000, 21'b0_000_0000_0001_00000_00_00);
  add_row("fetch_enable",      20'b1000_000_00_0000_000_0000, 21'b0_000_0000_0001_00000_00_00);
  add_row("boot_set",          20'b1000_000_00_0000_000_0000, 21'b1_000_0001_0001_10000_00_00);
  add_row("first_fetch_wait",  20'b1000_000_00_0000_000_0000, 21'b0_000_0001_0001_10000_00_00);
  add_row("first_fetch_ready", 20'b1010_000_00_0000_000_0000, 21'b0_000_0001_0001_10000_00_00);
  add_row("decode_valid",      20'b1110_000_00_0000_000_0000, 21'b0_000_0011_0000_10000_00_00);

  // jal with decode back-pressure, redirect fires only once
  add_row("jal_redirect",      20'b1100_000_01_0000_000_0000, 21'b1_001_0011_0000_10000_00_00);
  add_row("jal_no_repeat",     20'b1100_000_01_0000_000_0000, 21'b0_001_0011_0000_10000_00_00);
  add_row("jal_accept",        20'b1110_000_01_0000_000_0000, 21'b0_001_0011_0000_10000_00_00);

  // jalr waits for its base register from writeback
  add_row("jalr_stall",        20'b1110_000_10_0000_010_1000, 21'b0_001_0011_0011_10000_10_00);
  add_row("jalr_go",           20'b1110_000_10_0000_000_0000, 21'b1_001_0011_0000_10000_00_00);

  // taken branch, then taken branch with an external interrupt
  add_row("branch_taken",      20'b1110_000_00_1000_000_0000, 21'b1_010_0001_0001_10000_00_00);
  add_row("branch_irq",        20'b1110_000_00_1001_000_0000, 21'b1_011_0101_1001_10010_00_00);

  // load-use on operand b, then forwarding priority
  add_row("load_use",          20'b1110_000_00_0100_100_0001, 21'b0_000_0011_0101_10000_00_00);
  add_row("fwd_priority",      20'b1110_000_00_0000_011_1110, 21'b0_000_0011_0000_10000_01_10);
  add_row("fwd_ex_only",       20'b1110_000_00_0000_001_0001, 21'b0_000_0011_0000_10000_00_01);

  // wfi flush, drain, sleep, interrupt wake-up
  add_row("pipe_flush",        20'b1110_001_00_0000_000_0000, 21'b0_000_1111_0000_10000_00_00);
  add_row("flush_ex_wait",     20'b0000_000_00_0000_000_0000, 21'b0_000_1101_0001_10000_00_00);
  add_row("flush_ex_done",     20'b0001_000_00_0000_000_0000, 21'b0_000_1101_0001_10000_00_00);
  add_row("flush_wb",          20'b0000_000_00_0000_000_0000, 21'b0_000_1101_0001_10000_00_00);
  add_row("sleep",             20'b0000_000_00_0000_000_0000, 21'b0_000_1100_0001_00000_00_00);
  add_row("sleep_wake",        20'b0000_000_00_0010_000_0000, 21'b0_000_1100_0001_00000_00_00);
  add_row("wake_exception",    20'b0010_000_00_0010_000_0000, 21'b1_011_0001_1001_11000_00_00);

  // eret held in decode, single redirect
  add_row("eret_redirect",     20'b1100_010_00_0000_000_0000, 21'b1_100_0011_0000_10001_00_00);
  add_row("eret_no_repeat",    20'b1100_010_00_0000_000_0000, 21'b0_100_0011_0000_10001_00_00);
  add_row("illegal_insn",      20'b1110_100_00_0000_000_0000, 21'b0_000_0011_0001_10000_00_00);
  add_row("decode_resume",     20'b1110_000_00_0000_000_0000, 21'b0_000_0011_0000_10000_00_00);

  // exception taken by the instruction in decode
  add_row("decode_exception",  20'b1110_000_00_0010_000_0000, 21'b1_011_0011_1000_10100_00_00);
endtask

`endif

//--- tests/core_ctrl_tb.sv
/*
  table driven testbench for core_ctrl. inputs change on the rising edge,
  outputs are sampled mid cycle; row layout is given in the vectors header
*/
`timescale 1ns/1ps

module core_ctrl_tb;

  localparam int RESET_CYCLES = 16;

  logic clk = 1'b0;
  logic rst_n;

  // all DUT inputs packed, one bit field per port
  logic [19:0] stim;
  // checked DUT outputs, same layout as the expected column
  wire  [20:0] act;
  logic [20:0] row_exp;

  // stimulus table
  string       names[$];
  logic [19:0] row_in[$];
  logic [20:0] row_out[$];

  int row_errs;
  int pass_cnt;
  int fail_cnt;
  int cycles = 0;
  int cycle_limit;

  always #2 clk = ~clk;

  core_ctrl DUT (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (stim[19]),
    .instr_valid_i          (stim[18]),
    .id_ready_i             (stim[17]),
    .ex_valid_i             (stim[16]),
    .instr_req_o            (act[8]),
    .ctrl_busy_o            (act[13]),
    .is_decoding_o          (act[14]),
    .illegal_insn_i         (stim[15]),
    .eret_insn_i            (stim[14]),
    .pipe_flush_i           (stim[13]),
    .jump_in_dec_i          (stim[12:11]),
    .deassert_we_o          (act[9]),
    .branch_taken_ex_i      (stim[10]),
    .data_req_ex_i          (stim[9]),
    .pc_set_o               (act[20]),
    .pc_mux_o               (act[19:17]),
    .exc_req_i              (stim[8]),
    .ext_req_i              (stim[7]),
    .exc_ack_o              (act[12]),
    .exc_save_if_o          (act[7]),
    .exc_save_id_o          (act[6]),
    .exc_save_takenbranch_o (act[5]),
    .exc_restore_id_o       (act[4]),
    .regfile_we_ex_i        (stim[6]),
    .regfile_we_wb_i        (stim[5]),
    .regfile_alu_we_fw_i    (stim[4]),
    .reg_d_wb_is_reg_a_i    (stim[3]),
    .reg_d_wb_is_reg_b_i    (stim[2]),
    .reg_d_alu_is_reg_a_i   (stim[1]),
    .reg_d_alu_is_reg_b_i   (stim[0]),
    .operand_a_fw_mux_sel_o (act[3:2]),
    .operand_b_fw_mux_sel_o (act[1:0]),
    .halt_if_o              (act[16]),
    .halt_id_o              (act[15]),
    .load_stall_o           (act[11]),
    .jr_stall_o             (act[10])
  );

  task automatic add_row(input string name, input logic [19:0] in_v, input logic [20:0] out_v);
    names.push_back(name);
    row_in.push_back(in_v);
    row_out.push_back(out_v);
  endtask

  `include "core_ctrl_vectors.svh"

  // one output field of the current row
  task automatic check_field(input string row, input string field,
                             input logic [3:0] e, input logic [3:0] a);
    if (e !== a) begin
      $display("FAILED %s %s expected %0h actual %0h", row, field, e, a);
      row_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // reset, table loop, summary
  ////////////////////////////////////////////////////////////
  initial begin
    rst_n    = 1'b0;
    stim     = '0;
    row_exp  = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    build_table();
    cycle_limit = names.size() + RESET_CYCLES + 20;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < names.size(); i++) begin
      @(posedge clk);
      stim    <= row_in[i];
      row_exp  = row_out[i];
      // outputs settle well before mid cycle
      @(negedge clk);
      row_errs = 0;
      check_field(names[i], "pc_set",      {3'b000, row_exp[20]},    {3'b000, act[20]});
      check_field(names[i], "pc_mux",      {1'b0, row_exp[19:17]},   {1'b0, act[19:17]});
      check_field(names[i], "halt_if",     {3'b000, row_exp[16]},    {3'b000, act[16]});
      check_field(names[i], "halt_id",     {3'b000, row_exp[15]},    {3'b000, act[15]});
      check_field(names[i], "is_decoding", {3'b000, row_exp[14]},    {3'b000, act[14]});
      check_field(names[i], "ctrl_busy",   {3'b000, row_exp[13]},    {3'b000, act[13]});
      check_field(names[i], "exc_ack",     {3'b000, row_exp[12]},    {3'b000, act[12]});
      check_field(names[i], "load_stall",  {3'b000, row_exp[11]},    {3'b000, act[11]});
      check_field(names[i], "jr_stall",    {3'b000, row_exp[10]},    {3'b000, act[10]});
      check_field(names[i], "deassert_we", {3'b000, row_exp[9]},     {3'b000, act[9]});
      check_field(names[i], "instr_req",   {3'b000, row_exp[8]},     {3'b000, act[8]});
      check_field(names[i], "save_if",     {3'b000, row_exp[7]},     {3'b000, act[7]});
      check_field(names[i], "save_id",     {3'b000, row_exp[6]},     {3'b000, act[6]});
      check_field(names[i], "save_tbr",    {3'b000, row_exp[5]},     {3'b000, act[5]});
      check_field(names[i], "restore_id",  {3'b000, row_exp[4]},     {3'b000, act[4]});
      check_field(names[i], "fw_sel_a",    {2'b00, row_exp[3:2]},    {2'b00, act[3:2]});
      check_field(names[i], "fw_sel_b",    {2'b00, row_exp[1:0]},    {2'b00, act[1:0]});
      if (row_errs == 0) begin
        pass_cnt++;
        $display("ok    %s", names[i]);
      end else begin
        fail_cnt++;
        $display("bad   %s, %0d field(s) wrong", names[i], row_errs);
      end
    end

    $display("tests run %0d, passed %0d, failed %0d", names.size(), pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
